//--- logic/mul_consts.svh
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// operand and result width of the RV64 datapath
`define MUL_XLEN 64

// request tag, wide enough to tell every request in flight apart
`define MUL_TAG_W 4

// request queue depth, also the request credits after reset
`define MUL_REQ_DEPTH 4

// result credits after reset, matches the consumer buffer
`define MUL_RES_CREDITS 2

// booth operands carry one extra sign bit
`define MUL_SRC_W 65
`define MUL_PROD_W 130

// radix-4 iterations over a 65-bit signed multiplier
`define MUL_STEPS 33

`endif

//--- logic/mul_pkg.sv
`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

	//**********************************************************************
	// operation encoding
	//**********************************************************************

	// MUL keeps the low half, the three MULH* forms keep the high half
	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3,
		MULW   = 3'd4
	} mul_op_e;

	//**********************************************************************
	// queue payloads
	//**********************************************************************

	// one request as it sits in the request queue, 3+64+64+4 bits
	typedef struct packed {
		mul_op_e              op;
		logic [`MUL_XLEN-1:0]  a;
		logic [`MUL_XLEN-1:0]  b;
		logic [`MUL_TAG_W-1:0] tag;
	} mul_req_t;

	// finished result waiting for an output credit
	typedef struct packed {
		logic [`MUL_XLEN-1:0]  value;
		logic [`MUL_TAG_W-1:0] tag;
	} mul_res_t;

endpackage

`default_nettype wire

//--- logic/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 2
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   flush,
	input  logic                   push,
	input  payload_t               push_data,
	input  logic                   pop,
	output payload_t               head,
	output logic                   empty,
	output logic [$clog2(DEPTH):0] count
);

	localparam int PTR_W = $clog2(DEPTH);

	// storage, no reset on the payload
	payload_t mem [DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;

	// wrap at DEPTH-1 so odd depths work too
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	//**********************************************************************
	// pointers and occupancy
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			// simultaneous push and pop leaves count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// oldest entry
	assign head  = mem[rd_ptr];
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- logic/mul_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_decode (
	input  logic                         clk,
	input  logic                         rst,
	// request queue head
	input  logic                         empty,
	input  mul_pkg::mul_op_e             head_op,
	input  logic [`MUL_XLEN-1:0]         head_a,
	input  logic [`MUL_XLEN-1:0]         head_b,
	input  logic [`MUL_TAG_W-1:0]        head_tag,
	output logic                         pop,
	// issue to the booth core
	input  logic                         core_busy,
	output logic                         start,
	output logic signed [`MUL_SRC_W-1:0] src_a,
	output logic signed [`MUL_SRC_W-1:0] src_b,
	output logic                         sel_hi,
	output logic                         is_word,
	output logic [`MUL_TAG_W-1:0]        tag
);

	import mul_pkg::*;

	// set for one cycle after an issue
	logic issued_q;

	//**********************************************************************
	// issue
	//**********************************************************************

	// pop and start together, head leaves the queue as it enters the core
	// issued_q spaces issues until core_busy has risen
	assign start = !empty && !core_busy && !issued_q;
	assign pop   = start;

	always_ff @(posedge clk) begin
		if (rst) begin
			issued_q <= 1'b0;
		end else begin
			issued_q <= start;
		end
	end

	//**********************************************************************
	// operand sign rules
	//**********************************************************************

	always_comb begin
		// default signed, low half of the product is the same either way
		src_a   = {head_a[`MUL_XLEN-1], head_a};
		src_b   = {head_b[`MUL_XLEN-1], head_b};
		sel_hi  = 1'b0;
		is_word = 1'b0;
		case (head_op)
			MULH: begin
				sel_hi = 1'b1;
			end
			MULHSU: begin
				// a signed, b unsigned
				sel_hi = 1'b1;
				src_b  = {1'b0, head_b};
			end
			MULHU: begin
				sel_hi = 1'b1;
				src_a  = {1'b0, head_a};
				src_b  = {1'b0, head_b};
			end
			MULW: begin
				// upper operand bits ignored
				is_word = 1'b1;
				src_a   = {{(`MUL_SRC_W-32){head_a[31]}}, head_a[31:0]};
				src_b   = {{(`MUL_SRC_W-32){head_b[31]}}, head_b[31:0]};
			end
			default: begin
				// plain MUL
				sel_hi = 1'b0;
			end
		endcase
	end

	// tag rides along untouched
	assign tag = head_tag;

endmodule

`default_nettype wire

//--- logic/booth_mul_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module booth_mul_core (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         flush,
	// issue side
	input  logic                         start,
	input  logic signed [`MUL_SRC_W-1:0] src_a,
	input  logic signed [`MUL_SRC_W-1:0] src_b,
	input  logic                         sel_hi_in,
	input  logic                         is_word_in,
	input  logic [`MUL_TAG_W-1:0]        tag_in,
	output logic                         core_busy,
	// result side
	input  logic                         result_room,
	output logic                         done,
	output logic [`MUL_PROD_W-1:0]       product,
	output logic                         sel_hi,
	output logic                         is_word,
	output logic [`MUL_TAG_W-1:0]        tag
);

	localparam int STEP_W = $clog2(`MUL_STEPS + 1);
	// multiplier plus one sign bit on top and the booth zero below
	localparam int MPLR_W = `MUL_SRC_W + 2;

	logic                      running_q;
	logic [STEP_W-1:0]         step_q;
	logic [`MUL_PROD_W-1:0]    acc_q;
	logic [`MUL_PROD_W-1:0]    mcand_q;
	logic [MPLR_W-1:0]         mplr_q;
	logic [`MUL_PROD_W-1:0]    pp;
	logic                      accept;
	logic                      stepping;

	//**********************************************************************
	// control
	//**********************************************************************

	// busy while computing, or while no result slot is free
	assign core_busy = running_q || !result_room;
	assign accept    = start && !core_busy;

	// steps 0..MUL_STEPS-1 accumulate, the last cycle only reports done
	assign stepping = running_q && (step_q != STEP_W'(`MUL_STEPS));
	assign done     = running_q && (step_q == STEP_W'(`MUL_STEPS));

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			running_q <= 1'b0;
			step_q    <= '0;
		end else if (accept) begin
			running_q <= 1'b1;
			step_q    <= '0;
		end else if (stepping) begin
			step_q <= step_q + 1'b1;
		end else if (done) begin
			// idle again, next start waits for result room
			running_q <= 1'b0;
		end
	end

	//**********************************************************************
	// radix-4 recoding
	//**********************************************************************

	// bits i+1, i, i-1 of the multiplier pick 0, +-a or +-2a
	always_comb begin
		case (mplr_q[2:0])
			3'b001, 3'b010: pp = mcand_q;
			3'b011:         pp = mcand_q << 1;
			3'b100:         pp = -(mcand_q << 1);
			3'b101, 3'b110: pp = -mcand_q;
			default:        pp = '0;
		endcase
	end

	//**********************************************************************
	// datapath
	//**********************************************************************

	// arithmetic is mod 2^130, wide enough for any 65x65 signed product
	always_ff @(posedge clk) begin
		if (accept) begin
			acc_q   <= '0;
			mcand_q <= {{(`MUL_PROD_W-`MUL_SRC_W){src_a[`MUL_SRC_W-1]}}, src_a};
			mplr_q  <= {src_b[`MUL_SRC_W-1], src_b, 1'b0};
			// side band held until the next start
			sel_hi  <= sel_hi_in;
			is_word <= is_word_in;
			tag     <= tag_in;
		end else if (stepping) begin
			acc_q   <= acc_q + pp;
			// multiplicand moves up by two weights each step
			mcand_q <= mcand_q << 2;
			// multiplier moves down, sign kept
			mplr_q  <= {{2{mplr_q[MPLR_W-1]}}, mplr_q[MPLR_W-1:2]};
		end
	end

	assign product = acc_q;

endmodule

`default_nettype wire

//--- logic/mul_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_result (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   flush,
	// from the booth core
	input  logic                   done,
	input  logic [`MUL_PROD_W-1:0] product,
	input  logic                   sel_hi,
	input  logic                   is_word,
	input  logic [`MUL_TAG_W-1:0]  tag,
	output logic                   result_room,
	// to the consumer
	input  logic                   res_credit,
	output logic                   res_valid,
	output logic [`MUL_XLEN-1:0]   res_value,
	output logic [`MUL_TAG_W-1:0]  res_tag
);

	import mul_pkg::*;

	localparam int RES_DEPTH = 2;
	localparam int CNT_W     = $clog2(RES_DEPTH) + 1;
	localparam int CRED_W    = $clog2(`MUL_RES_CREDITS + 1);

	logic [`MUL_XLEN-1:0] sel_value;
	mul_res_t             pend_data;
	logic                 pend_valid;
	mul_res_t             q_head;
	logic                 q_empty;
	logic [CNT_W-1:0]     q_count;
	logic [CNT_W:0]       used;
	logic [CRED_W-1:0]    credits;
	logic                 send;

	//**********************************************************************
	// half select and word extension
	//**********************************************************************

	always_comb begin
		if (sel_hi) begin
			sel_value = product[2*`MUL_XLEN-1:`MUL_XLEN];
		end else if (is_word) begin
			sel_value = {{32{product[31]}}, product[31:0]};
		end else begin
			sel_value = product[`MUL_XLEN-1:0];
		end
	end

	// one cycle in a holding register before the queue
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= done;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			pend_data.value <= sel_value;
			pend_data.tag   <= tag;
		end
	end

	sync_fifo #(
		.payload_t (mul_res_t),
		.DEPTH     (RES_DEPTH)
	) res_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.push      (pend_valid),
		.push_data (pend_data),
		.pop       (send),
		.head      (q_head),
		.empty     (q_empty),
		.count     (q_count)
	);

	// the held result already owns a slot
	assign used        = {1'b0, q_count} + (CNT_W+1)'(pend_valid);
	assign result_room = used < (CNT_W+1)'(RES_DEPTH);

	//**********************************************************************
	// credit-gated send
	//**********************************************************************

	assign send = (credits != '0) && !q_empty;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			credits   <= CRED_W'(`MUL_RES_CREDITS);
			res_valid <= 1'b0;
		end else begin
			// spend on send, regain on each consumer pulse
			credits   <= credits - CRED_W'(send) + CRED_W'(res_credit);
			res_valid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			res_value <= q_head.value;
			res_tag   <= q_head.tag;
		end
	end

endmodule

`default_nettype wire

//--- logic/mul_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_unit_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush,
	// request side, credit controlled
	input  logic                  req_valid,
	input  mul_pkg::mul_op_e      req_op,
	input  logic [`MUL_XLEN-1:0]  req_a,
	input  logic [`MUL_XLEN-1:0]  req_b,
	input  logic [`MUL_TAG_W-1:0] req_tag,
	output logic                  req_credit,
	// result side
	output logic                  res_valid,
	output logic [`MUL_XLEN-1:0]  res_value,
	output logic [`MUL_TAG_W-1:0] res_tag,
	input  logic                  res_credit
);

	import mul_pkg::*;

	mul_req_t req_in;
	mul_req_t req_head;
	logic     req_empty;
	logic     req_pop;

	// decode to core
	logic                         start;
	logic signed [`MUL_SRC_W-1:0] src_a;
	logic signed [`MUL_SRC_W-1:0] src_b;
	logic                         dec_sel_hi;
	logic                         dec_is_word;
	logic [`MUL_TAG_W-1:0]        dec_tag;
	logic                         core_busy;

	// core to result
	logic                         done;
	logic [`MUL_PROD_W-1:0]       product;
	logic                         core_sel_hi;
	logic                         core_is_word;
	logic [`MUL_TAG_W-1:0]        core_tag;
	logic                         result_room;

	//**********************************************************************
	// request queue
	//**********************************************************************

	always_comb begin
		req_in.op  = req_op;
		req_in.a   = req_a;
		req_in.b   = req_b;
		req_in.tag = req_tag;
	end

	// producer credits keep this from ever seeing a full queue
	sync_fifo #(
		.payload_t (mul_req_t),
		.DEPTH     (`MUL_REQ_DEPTH)
	) req_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.push      (req_valid),
		.push_data (req_in),
		.pop       (req_pop),
		.head      (req_head),
		.empty     (req_empty),
		.count     ()
	);

	// credit back one cycle after each pop, none for flushed entries
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			req_credit <= 1'b0;
		end else begin
			req_credit <= req_pop;
		end
	end

	//**********************************************************************
	// stages
	//**********************************************************************

	mul_decode mul_decode_inst (
		.clk       (clk),
		.rst       (rst),
		.empty     (req_empty),
		.head_op   (req_head.op),
		.head_a    (req_head.a),
		.head_b    (req_head.b),
		.head_tag  (req_head.tag),
		.pop       (req_pop),
		.core_busy (core_busy),
		.start     (start),
		.src_a     (src_a),
		.src_b     (src_b),
		.sel_hi    (dec_sel_hi),
		.is_word   (dec_is_word),
		.tag       (dec_tag)
	);

	booth_mul_core booth_mul_core_inst (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.start       (start),
		.src_a       (src_a),
		.src_b       (src_b),
		.sel_hi_in   (dec_sel_hi),
		.is_word_in  (dec_is_word),
		.tag_in      (dec_tag),
		.core_busy   (core_busy),
		.result_room (result_room),
		.done        (done),
		.product     (product),
		.sel_hi      (core_sel_hi),
		.is_word     (core_is_word),
		.tag         (core_tag)
	);

	mul_result mul_result_inst (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.done        (done),
		.product     (product),
		.sel_hi      (core_sel_hi),
		.is_word     (core_is_word),
		.tag         (core_tag),
		.result_room (result_room),
		.res_credit  (res_credit),
		.res_valid   (res_valid),
		.res_value   (res_value),
		.res_tag     (res_tag)
	);

endmodule

`default_nettype wire

//--- bench/mul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_tb;

	import mul_pkg::*;

	// generous bound for one result, a few core passes
	localparam int WAIT_LIMIT = 20 * (`MUL_STEPS + 4);
	// quiet window used to prove nothing more arrives
	localparam int WINDOW     = 3 * (`MUL_STEPS + 4);

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  flush;
	logic                  req_valid;
	mul_op_e               req_op;
	logic [`MUL_XLEN-1:0]  req_a;
	logic [`MUL_XLEN-1:0]  req_b;
	logic [`MUL_TAG_W-1:0] req_tag;
	logic                  req_credit;
	logic                  res_valid;
	logic [`MUL_XLEN-1:0]  res_value;
	logic [`MUL_TAG_W-1:0] res_tag;
	logic                  res_credit = 1'b0;

	// expected results in send order, main process only
	mul_res_t              exp_q[$];
	int                    sent_total;
	int                    got_rd;
	logic                  grant_en;
	logic [`MUL_TAG_W-1:0] next_tag;

	// written by the negedge monitor only
	mul_res_t              got_q[$];
	mul_res_t              seen;
	int                    credit_pulses = 0;
	int                    pending_grants = 0;
	logic                  grant_next = 1'b0;

	mul_unit_top mul_unit_top_inst (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_a      (req_a),
		.req_b      (req_b),
		.req_tag    (req_tag),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res_value  (res_value),
		.res_tag    (res_tag),
		.res_credit (res_credit)
	);

	// 40 ns period
	always #20 clk = ~clk;

	//**********************************************************************
	// reference model
	//**********************************************************************

	// 128-bit product of the extended operands, then half select
	function automatic logic [63:0] model(input mul_op_e op, input logic [63:0] a,
			input logic [63:0] b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] p;
		logic [63:0]  r;
		ea = {{64{a[63]}}, a};
		eb = {{64{b[63]}}, b};
		case (op)
			MULHSU: begin
				eb = {64'b0, b};
			end
			MULHU: begin
				ea = {64'b0, a};
				eb = {64'b0, b};
			end
			MULW: begin
				// upper operand halves play no part
				ea = {{96{a[31]}}, a[31:0]};
				eb = {{96{b[31]}}, b[31:0]};
			end
			default: begin
				ea = ea;
			end
		endcase
		p = ea * eb;
		case (op)
			MUL:     r = p[63:0];
			MULW:    r = {{32{p[31]}}, p[31:0]};
			default: r = p[127:64];
		endcase
		return r;
	endfunction

	// request credits still held by the bench
	function automatic int credits_left();
		return `MUL_REQ_DEPTH - (sent_total - credit_pulses);
	endfunction

	//**********************************************************************
	// compare and stop
	//**********************************************************************

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input mul_res_t exp, input mul_res_t act);
		if (act !== exp) begin
			$display("ERROR %s expected value %h tag %h actual value %h tag %h",
				name, exp.value, exp.tag, act.value, act.tag);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR %s expected %0d actual %0d", name, exp, act);
			$display("Result: FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	//**********************************************************************
	// monitor, sampled mid cycle where outputs are settled
	//**********************************************************************

	always @(negedge clk) begin
		if (rst || flush) begin
			// bench counts follow the DUT back to reset values
			credit_pulses  = 0;
			pending_grants = 0;
			grant_next     = 1'b0;
		end else begin
			if (res_valid) begin
				seen.value = res_value;
				seen.tag   = res_tag;
				got_q.push_back(seen);
				pending_grants++;
			end
			if (req_credit) begin
				credit_pulses++;
				if (credit_pulses > sent_total) begin
					abort_run("more req_credit pulses than requests sent");
				end
			end
			// one buffer slot handed back per cycle
			grant_next = grant_en && (pending_grants > 0);
			if (grant_next) begin
				pending_grants--;
			end
		end
	end

	always @(posedge clk) begin
		#2;
		res_credit = grant_next;
	end

	//**********************************************************************
	// drive and wait helpers
	//**********************************************************************

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_req(input mul_op_e op, input logic [63:0] a, input logic [63:0] b);
		mul_res_t e;
		int       waited;
		waited = 0;
		while (credits_left() == 0) begin
			if (waited >= WAIT_LIMIT) begin
				abort_run("timed out waiting for a request credit");
			end
			idle_cycles(1);
			waited++;
		end
		req_valid = 1'b1;
		req_op    = op;
		req_a     = a;
		req_b     = b;
		req_tag   = next_tag;
		e.value   = model(op, a, b);
		e.tag     = next_tag;
		exp_q.push_back(e);
		sent_total++;
		next_tag++;
		idle_cycles(1);
		req_valid = 1'b0;
	endtask

	task automatic wait_count(input string name, input int n);
		int waited;
		waited = 0;
		while (got_q.size() < n) begin
			if (waited >= WAIT_LIMIT) begin
				abort_run($sformatf("%s timed out waiting for a result", name));
			end
			idle_cycles(1);
			waited++;
		end
	endtask

	task automatic wait_pulses(input string name, input int n);
		int waited;
		waited = 0;
		while (credit_pulses < n) begin
			if (waited >= WAIT_LIMIT) begin
				abort_run($sformatf("%s timed out waiting for req_credit", name));
			end
			idle_cycles(1);
			waited++;
		end
	endtask

	// compare everything expected, then hand back every credit owed
	task automatic drain(input string name);
		mul_res_t got;
		int       waited;
		while (exp_q.size() > 0) begin
			wait_count(name, got_rd + 1);
			got = got_q[got_rd];
			got_rd++;
			check_value(name, exp_q.pop_front(), got);
		end
		waited = 0;
		while (pending_grants > 0 || grant_next) begin
			if (waited >= WAIT_LIMIT) begin
				abort_run($sformatf("%s timed out returning result credits", name));
			end
			idle_cycles(1);
			waited++;
		end
		idle_cycles(2);
	endtask

	//**********************************************************************
	// tests
	//**********************************************************************

	task automatic directed_ops();
		logic [63:0] vals [6];
		mul_op_e     op;
		vals = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
			64'h7fff_ffff_ffff_ffff, 64'hffff_fffe_1234_5679};
		grant_en = 1'b1;
		for (int o = 0; o < 5; o++) begin
			op = mul_op_e'(3'(o));
			// every pair, so all sign mixes show up
			for (int i = 0; i < 6; i++) begin
				for (int j = 0; j < 6; j++) begin
					send_req(op, vals[i], vals[j]);
				end
			end
			drain($sformatf("directed_%s", op.name()));
		end
	endtask

	task automatic mulw_sign_ext();
		grant_en = 1'b1;
		// junk in the upper halves, bit 31 of the product set
		send_req(MULW, 64'hdead_beef_0001_0000, 64'h1234_5678_0000_8000);
		send_req(MULW, 64'hffff_0000_7fff_ffff, 64'h0000_0001_0000_0002);
		send_req(MULW, 64'h0123_4567_ffff_ffff, 64'h89ab_cdef_ffff_ffff);
		send_req(MULW, 64'h8000_0000_8000_0000, 64'h7fff_ffff_0000_0001);
		drain("mulw_sign_ext");
	endtask

	task automatic random_stream();
		grant_en = 1'b1;
		// back to back, paced only by request credits
		for (int n = 0; n < 48; n++) begin
			send_req(mul_op_e'(3'($urandom % 5)), {$urandom, $urandom}, {$urandom, $urandom});
		end
		drain("random_stream");
	endtask

	task automatic result_backpressure();
		int base;
		grant_en = 1'b0;
		base     = got_q.size();
		for (int n = 0; n < 6; n++) begin
			send_req(mul_op_e'(3'($urandom % 5)), {$urandom, $urandom}, {$urandom, $urandom});
		end
		wait_count("result_backpressure", base + `MUL_RES_CREDITS);
		idle_cycles(WINDOW);
		// only the initial result credits can be spent
		check_count("result_backpressure", base + `MUL_RES_CREDITS, got_q.size());
		grant_en = 1'b1;
		drain("result_backpressure");
	endtask

	task automatic request_credits();
		int sent_base;
		int pulse_base;
		grant_en   = 1'b0;
		sent_base  = sent_total;
		pulse_base = credit_pulses;
		for (int n = 0; n < 6; n++) begin
			send_req(MULHU, {$urandom, $urandom}, {$urandom, $urandom});
		end
		// long enough for every request to pop if nothing held them back
		idle_cycles(2 * WINDOW);
		// req_credit stops once back-pressure reaches the request queue
		check_count("request_credits_stalled", 1,
			int'((credit_pulses - pulse_base) < (sent_total - sent_base)));
		grant_en = 1'b1;
		drain("request_credits");
		// one pulse per request once everything is out
		check_count("request_credits_pulses", sent_total - sent_base, credit_pulses - pulse_base);
		check_count("request_credits_left", `MUL_REQ_DEPTH, credits_left());
	endtask

	task automatic flush_drop();
		int pulse_base;
		grant_en   = 1'b1;
		pulse_base = credit_pulses;
		send_req(MUL, 64'h1111_2222_3333_4444, 64'h5);
		send_req(MULH, 64'h8000_0000_0000_0001, 64'h3);
		send_req(MULW, 64'h0000_0000_ffff_0000, 64'h2);
		// first request is in the core, the rest are queued
		wait_pulses("flush_drop", pulse_base + 1);
		flush      = 1'b1;
		sent_total = 0;
		exp_q.delete();
		idle_cycles(1);
		flush = 1'b0;
		idle_cycles(WINDOW);
		check_count("flush_drop_results", got_rd, got_q.size());
		send_req(MULHSU, 64'hffff_ffff_ffff_fff0, 64'h8000_0000_0000_0000);
		drain("flush_drop");
		// one pulse for the new request and none for the dropped ones
		check_count("flush_drop_credits", `MUL_REQ_DEPTH, credits_left());
	endtask

	//**********************************************************************
	// main sequence
	//**********************************************************************

	initial begin
		void'($urandom(32'h2449_6cb5));
		rst        = 1'b1;
		flush      = 1'b0;
		req_valid  = 1'b0;
		req_op     = MUL;
		req_a      = '0;
		req_b      = '0;
		req_tag    = '0;
		grant_en   = 1'b0;
		next_tag   = '0;
		sent_total = 0;
		got_rd     = 0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		check_count("reset_outputs", 0, int'(res_valid) + int'(req_credit));
		directed_ops();
		mulw_sign_ext();
		random_stream();
		result_backpressure();
		request_credits();
		flush_drop();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/mul_pkg.sv
logic/sync_fifo.sv
logic/mul_decode.sv
logic/booth_mul_core.sv
logic/mul_result.sv
logic/mul_unit_top.sv
bench/mul_tb.sv

//--- Makefile
# Verilator flow for the multiply unit
# override on the command line, e.g. make sim SEED=7

VERILATOR ?= verilator
TOP       ?= mul_tb
RTL_TOP   ?= mul_unit_top
SEED      ?= 1
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# pass only when the bench prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)
